/* src/ac_pkg.sv */
`default_nettype none

package ac_pkg;

  localparam int num_tiles_lp = 4;

  localparam int cord_width_lp   = 2;
  localparam int opcode_width_lp = 2;
  localparam int tag_width_lp    = 4;
  localparam int data_width_lp   = 16;

  localparam int cmd_flit_width_lp =
    cord_width_lp + opcode_width_lp + tag_width_lp + data_width_lp;
  localparam int resp_flit_width_lp =
    cord_width_lp + tag_width_lp + data_width_lp;

  typedef logic [cord_width_lp-1:0]      cord_t;
  typedef logic [opcode_width_lp-1:0]    opcode_t;
  typedef logic [tag_width_lp-1:0]       tag_t;
  typedef logic [data_width_lp-1:0]      data_t;
  typedef logic [cmd_flit_width_lp-1:0]  cmd_flit_t;   // {dest, opcode, tag, data}
  typedef logic [resp_flit_width_lp-1:0] resp_flit_t;  // {src, tag, result}

  // Low bit of each command field
  localparam int cmd_tag_lsb_lp  = data_width_lp;
  localparam int cmd_op_lsb_lp   = cmd_tag_lsb_lp + tag_width_lp;
  localparam int cmd_dest_lsb_lp = cmd_op_lsb_lp + opcode_width_lp;

  localparam opcode_t op_load_lp = 2'd0;  // Acc takes operand
  localparam opcode_t op_add_lp  = 2'd1;  // Wraps at 2^16
  localparam opcode_t op_xor_lp  = 2'd2;
  localparam opcode_t op_read_lp = 2'd3;  // Acc unchanged

  typedef enum logic
  {
    pri_local = 1'b0,
    pri_east  = 1'b1
  } arb_pri_e;

endpackage

`default_nettype wire

/* src/ac_link_fifo.sv */
`default_nettype none

module ac_link_fifo
  #(parameter type flit_t = logic [7:0])
  (input  wire   core_clk_i,
   input  wire   arst_n_i,

   input  wire   flit_t data_i,
   input  wire   valid_i,
   output logic  ready_o,

   output flit_t data_o,
   output logic  valid_o,
   input  wire   ready_i
  );

  flit_t out_data_r;
  flit_t skid_data_r;
  logic  out_valid_r;
  logic  skid_valid_r;

  logic  enq;
  logic  deq;
  logic  load_out;

  assign ready_o  = ~skid_valid_r;  // Occupancy only
  assign enq      = valid_i & ready_o;
  assign deq      = out_valid_r & ready_i;
  assign load_out = deq | ~out_valid_r;

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      out_valid_r  <= 1'b0;
      skid_valid_r <= 1'b0;
    end
    else if (load_out)
    begin
      out_valid_r  <= skid_valid_r | enq;
      skid_valid_r <= 1'b0;  // Skid moves forward or was empty
    end
    else
    begin
      skid_valid_r <= skid_valid_r | enq;
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (load_out)
      out_data_r <= skid_valid_r ? skid_data_r : data_i;
    if (!load_out && enq)
      skid_data_r <= data_i;  // Output stalled, park here
  end

  assign data_o  = out_data_r;
  assign valid_o = out_valid_r;

  // Stalled flit must not move or vanish
  hold_a: assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

`default_nettype wire

/* src/ac_tile_router.sv */
`default_nettype none

module ac_tile_router
  (input  wire                core_clk_i,
   input  wire                arst_n_i,

   input  wire ac_pkg::cord_t my_cord_i,

   input  wire ac_pkg::cmd_flit_t    cmd_flit_i,
   input  wire                       cmd_valid_i,
   output logic                      cmd_ready_o,

   output ac_pkg::cmd_flit_t         local_cmd_flit_o,
   output logic                      local_cmd_valid_o,
   input  wire                       local_cmd_ready_i,

   output logic                      east_cmd_valid_o,
   input  wire                       east_cmd_ready_i,

   input  wire ac_pkg::resp_flit_t   local_resp_flit_i,
   input  wire                       local_resp_valid_i,
   output logic                      local_resp_ready_o,

   input  wire ac_pkg::resp_flit_t   east_resp_flit_i,
   input  wire                       east_resp_valid_i,
   output logic                      east_resp_ready_o,

   output ac_pkg::resp_flit_t        west_resp_flit_o,
   output logic                      west_resp_valid_o,
   input  wire                       west_resp_ready_i
  );

  ac_pkg::cord_t    dest_li;
  logic             is_local;

  ac_pkg::arb_pri_e pri_r;
  logic             grant_local;
  logic             grant_east;

  // Command steering
  assign dest_li  = cmd_flit_i[ac_pkg::cmd_dest_lsb_lp +: ac_pkg::cord_width_lp];
  assign is_local = (dest_li == my_cord_i);

  assign local_cmd_flit_o  = cmd_flit_i;
  assign local_cmd_valid_o = cmd_valid_i & is_local;
  assign east_cmd_valid_o  = cmd_valid_i & ~is_local;
  assign cmd_ready_o       = is_local ? local_cmd_ready_i : east_cmd_ready_i;

  // Round-robin merge going west
  assign grant_local = local_resp_valid_i
                       & (~east_resp_valid_i | (pri_r == ac_pkg::pri_local));
  assign grant_east  = east_resp_valid_i & ~grant_local;

  assign west_resp_valid_o  = local_resp_valid_i | east_resp_valid_i;
  assign west_resp_flit_o   = grant_local ? local_resp_flit_i : east_resp_flit_i;
  assign local_resp_ready_o = grant_local & west_resp_ready_i;
  assign east_resp_ready_o  = grant_east & west_resp_ready_i;

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      pri_r <= ac_pkg::pri_local;
    else if (west_resp_valid_o && west_resp_ready_i)
      pri_r <= grant_local ? ac_pkg::pri_east : ac_pkg::pri_local;  // Favor the loser
  end

  // Grant alternates while both sources wait
  merge_a: assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
    local_resp_valid_i && east_resp_valid_i && west_resp_ready_i
      |=> !(local_resp_valid_i && east_resp_valid_i)
          || (grant_local != $past(grant_local)));

endmodule

`default_nettype wire

/* src/ac_accum_engine.sv */
`default_nettype none

module ac_accum_engine
  (input  wire                      core_clk_i,
   input  wire                      arst_n_i,

   input  wire ac_pkg::cord_t       my_cord_i,

   input  wire ac_pkg::cmd_flit_t   cmd_flit_i,
   input  wire                      cmd_valid_i,
   output logic                     cmd_ready_o,

   output ac_pkg::resp_flit_t       resp_flit_o,
   output logic                     resp_valid_o,
   input  wire                      resp_ready_i
  );

  ac_pkg::opcode_t    op_li;
  ac_pkg::tag_t       tag_li;
  ac_pkg::data_t      operand_li;

  ac_pkg::data_t      acc_r;
  ac_pkg::data_t      acc_nxt;
  ac_pkg::resp_flit_t resp_flit_r;
  logic               resp_valid_r;
  logic               accept;

  assign op_li      = cmd_flit_i[ac_pkg::cmd_op_lsb_lp +: ac_pkg::opcode_width_lp];
  assign tag_li     = cmd_flit_i[ac_pkg::cmd_tag_lsb_lp +: ac_pkg::tag_width_lp];
  assign operand_li = cmd_flit_i[ac_pkg::data_width_lp-1:0];

  assign cmd_ready_o = ~resp_valid_r | resp_ready_i;  // Empty or draining now
  assign accept      = cmd_valid_i & cmd_ready_o;

  always_comb
  begin
    case (op_li)
      ac_pkg::op_load_lp: acc_nxt = operand_li;
      ac_pkg::op_add_lp:  acc_nxt = acc_r + operand_li;
      ac_pkg::op_xor_lp:  acc_nxt = acc_r ^ operand_li;
      default:            acc_nxt = acc_r;  // op_read
    endcase
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      acc_r        <= '0;
      resp_valid_r <= 1'b0;
    end
    else if (accept)
    begin
      acc_r        <= acc_nxt;
      resp_valid_r <= 1'b1;
    end
    else if (resp_ready_i)
    begin
      resp_valid_r <= 1'b0;
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (accept)
      resp_flit_r <= {my_cord_i, tag_li, acc_nxt};
  end

  assign resp_flit_o  = resp_flit_r;
  assign resp_valid_o = resp_valid_r;

endmodule

`default_nettype wire

/* src/ac_tile_node.sv */
`default_nettype none

module ac_tile_node
  (input  wire                      core_clk_i,
   input  wire                      arst_n_i,

   input  wire ac_pkg::cord_t       my_cord_i,

   input  wire ac_pkg::cmd_flit_t   west_cmd_flit_i,
   input  wire                      west_cmd_valid_i,
   output logic                     west_cmd_ready_o,

   output ac_pkg::cmd_flit_t        east_cmd_flit_o,
   output logic                     east_cmd_valid_o,
   input  wire                      east_cmd_ready_i,

   input  wire ac_pkg::resp_flit_t  east_resp_flit_i,
   input  wire                      east_resp_valid_i,
   output logic                     east_resp_ready_o,

   output ac_pkg::resp_flit_t       west_resp_flit_o,
   output logic                     west_resp_valid_o,
   input  wire                      west_resp_ready_i
  );

  ac_pkg::cmd_flit_t  cmd_flit_buf;
  logic               cmd_valid_buf;
  logic               cmd_ready_buf;

  ac_pkg::cmd_flit_t  eng_cmd_flit;
  logic               eng_cmd_valid;
  logic               eng_cmd_ready;

  ac_pkg::resp_flit_t eng_resp_flit;
  logic               eng_resp_valid;
  logic               eng_resp_ready;

  ac_pkg::resp_flit_t merged_resp_flit;
  logic               merged_resp_valid;
  logic               merged_resp_ready;

  ac_link_fifo #(.flit_t(ac_pkg::cmd_flit_t)) cmd_in_fifo
    (.core_clk_i (core_clk_i),
     .arst_n_i   (arst_n_i),
     .data_i     (west_cmd_flit_i),
     .valid_i    (west_cmd_valid_i),
     .ready_o    (west_cmd_ready_o),
     .data_o     (cmd_flit_buf),
     .valid_o    (cmd_valid_buf),
     .ready_i    (cmd_ready_buf)
    );

  assign east_cmd_flit_o = cmd_flit_buf;  // Pass-through flit, valid from router

  ac_tile_router router
    (.core_clk_i         (core_clk_i),
     .arst_n_i           (arst_n_i),
     .my_cord_i          (my_cord_i),
     .cmd_flit_i         (cmd_flit_buf),
     .cmd_valid_i        (cmd_valid_buf),
     .cmd_ready_o        (cmd_ready_buf),
     .local_cmd_flit_o   (eng_cmd_flit),
     .local_cmd_valid_o  (eng_cmd_valid),
     .local_cmd_ready_i  (eng_cmd_ready),
     .east_cmd_valid_o   (east_cmd_valid_o),
     .east_cmd_ready_i   (east_cmd_ready_i),
     .local_resp_flit_i  (eng_resp_flit),
     .local_resp_valid_i (eng_resp_valid),
     .local_resp_ready_o (eng_resp_ready),
     .east_resp_flit_i   (east_resp_flit_i),
     .east_resp_valid_i  (east_resp_valid_i),
     .east_resp_ready_o  (east_resp_ready_o),
     .west_resp_flit_o   (merged_resp_flit),
     .west_resp_valid_o  (merged_resp_valid),
     .west_resp_ready_i  (merged_resp_ready)
    );

  ac_accum_engine engine
    (.core_clk_i   (core_clk_i),
     .arst_n_i     (arst_n_i),
     .my_cord_i    (my_cord_i),
     .cmd_flit_i   (eng_cmd_flit),
     .cmd_valid_i  (eng_cmd_valid),
     .cmd_ready_o  (eng_cmd_ready),
     .resp_flit_o  (eng_resp_flit),
     .resp_valid_o (eng_resp_valid),
     .resp_ready_i (eng_resp_ready)
    );

  ac_link_fifo #(.flit_t(ac_pkg::resp_flit_t)) resp_out_fifo
    (.core_clk_i (core_clk_i),
     .arst_n_i   (arst_n_i),
     .data_i     (merged_resp_flit),
     .valid_i    (merged_resp_valid),
     .ready_o    (merged_resp_ready),
     .data_o     (west_resp_flit_o),
     .valid_o    (west_resp_valid_o),
     .ready_i    (west_resp_ready_i)
    );

endmodule

`default_nettype wire

/* src/ac_complex.sv */
`default_nettype none

module ac_complex
  (input  wire                      core_clk_i,
   input  wire                      arst_n_i,

   input  wire ac_pkg::cmd_flit_t   cmd_flit_i,
   input  wire                      cmd_valid_i,
   output logic                     cmd_ready_o,

   output ac_pkg::resp_flit_t       resp_flit_o,
   output logic                     resp_valid_o,
   input  wire                      resp_ready_i
  );

  // Link k enters tile k from the west; link num_tiles_lp is the east edge
  ac_pkg::cmd_flit_t  cmd_flit_link  [ac_pkg::num_tiles_lp+1];
  logic               cmd_valid_link [ac_pkg::num_tiles_lp+1];
  logic               cmd_ready_link [ac_pkg::num_tiles_lp+1];

  // Link k leaves tile k toward the west
  ac_pkg::resp_flit_t resp_flit_link  [ac_pkg::num_tiles_lp+1];
  logic               resp_valid_link [ac_pkg::num_tiles_lp+1];
  logic               resp_ready_link [ac_pkg::num_tiles_lp+1];

  assign cmd_flit_link[0]  = cmd_flit_i;
  assign cmd_valid_link[0] = cmd_valid_i;
  assign cmd_ready_o       = cmd_ready_link[0];

  assign resp_flit_o        = resp_flit_link[0];
  assign resp_valid_o       = resp_valid_link[0];
  assign resp_ready_link[0] = resp_ready_i;

  // East edge
  assign cmd_ready_link[ac_pkg::num_tiles_lp]  = 1'b1;  // Misrouted commands drain
  assign resp_flit_link[ac_pkg::num_tiles_lp]  = '0;
  assign resp_valid_link[ac_pkg::num_tiles_lp] = 1'b0;

  for (genvar i = 0; i < ac_pkg::num_tiles_lp; i++)
  begin : tile
    localparam ac_pkg::cord_t my_cord_lp = ac_pkg::cord_t'(i);

    ac_tile_node node
      (.core_clk_i        (core_clk_i),
       .arst_n_i          (arst_n_i),
       .my_cord_i         (my_cord_lp),
       .west_cmd_flit_i   (cmd_flit_link[i]),
       .west_cmd_valid_i  (cmd_valid_link[i]),
       .west_cmd_ready_o  (cmd_ready_link[i]),
       .east_cmd_flit_o   (cmd_flit_link[i+1]),
       .east_cmd_valid_o  (cmd_valid_link[i+1]),
       .east_cmd_ready_i  (cmd_ready_link[i+1]),
       .east_resp_flit_i  (resp_flit_link[i+1]),
       .east_resp_valid_i (resp_valid_link[i+1]),
       .east_resp_ready_o (resp_ready_link[i+1]),
       .west_resp_flit_o  (resp_flit_link[i]),
       .west_resp_valid_o (resp_valid_link[i]),
       .west_resp_ready_i (resp_ready_link[i])
      );
  end

  // Host must hold a stalled command
  host_hold_a: assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
    cmd_valid_i && !cmd_ready_o |=> cmd_valid_i && $stable(cmd_flit_i));

endmodule

`default_nettype wire

/* verif/ac_tb_vectors.svh */
// Columns are test, destination tile, opcode, tag, operand, expects response, expected result
// Tags stay unique within one test because a test drains before the next starts
localparam int num_vec_lp = 28;

vec_t vec_tbl [num_vec_lp] = '{
  '{1, 2'd0, ac_pkg::op_read_lp, 4'h0, 16'h0000, 1'b1, 16'h0000},  // All zero after reset
  '{1, 2'd1, ac_pkg::op_read_lp, 4'h1, 16'h0000, 1'b1, 16'h0000},
  '{1, 2'd2, ac_pkg::op_read_lp, 4'h2, 16'h0000, 1'b1, 16'h0000},
  '{1, 2'd3, ac_pkg::op_read_lp, 4'h3, 16'h0000, 1'b1, 16'h0000},
  '{2, 2'd1, ac_pkg::op_load_lp, 4'h0, 16'hfff0, 1'b1, 16'hfff0},
  '{2, 2'd1, ac_pkg::op_add_lp,  4'h1, 16'h0025, 1'b1, 16'h0015},  // Wraps past 2^16
  '{2, 2'd1, ac_pkg::op_xor_lp,  4'h2, 16'h00ff, 1'b1, 16'h00ea},
  '{2, 2'd1, ac_pkg::op_read_lp, 4'h3, 16'h1234, 1'b1, 16'h00ea},  // Operand ignored
  '{3, 2'd0, ac_pkg::op_load_lp, 4'h4, 16'h1111, 1'b1, 16'h1111},
  '{3, 2'd2, ac_pkg::op_load_lp, 4'h5, 16'h2222, 1'b1, 16'h2222},
  '{3, 2'd3, ac_pkg::op_add_lp,  4'h6, 16'h0303, 1'b1, 16'h0303},
  '{3, 2'd1, ac_pkg::op_read_lp, 4'h7, 16'h0000, 1'b1, 16'h00ea},
  '{4, 2'd3, ac_pkg::op_load_lp, 4'h8, 16'habcd, 1'b1, 16'habcd},
  '{4, 2'd3, ac_pkg::op_xor_lp,  4'h9, 16'h00ff, 1'b1, 16'hab32},
  '{4, 2'd0, ac_pkg::op_read_lp, 4'ha, 16'h0000, 1'b1, 16'h1111},  // Untouched by tile 3 traffic
  '{4, 2'd1, ac_pkg::op_read_lp, 4'hb, 16'h0000, 1'b1, 16'h00ea},
  '{4, 2'd2, ac_pkg::op_read_lp, 4'hc, 16'h0000, 1'b1, 16'h2222},
  '{5, 2'd0, ac_pkg::op_add_lp,  4'h0, 16'h0001, 1'b1, 16'h1112},
  '{5, 2'd1, ac_pkg::op_add_lp,  4'h1, 16'h0001, 1'b1, 16'h00eb},
  '{5, 2'd3, ac_pkg::op_add_lp,  4'h2, 16'h0001, 1'b1, 16'hab33},
  '{5, 2'd0, ac_pkg::op_add_lp,  4'h3, 16'h0001, 1'b1, 16'h1113},
  '{5, 2'd2, ac_pkg::op_add_lp,  4'h4, 16'h0002, 1'b1, 16'h2224},
  '{5, 2'd3, ac_pkg::op_xor_lp,  4'h5, 16'hffff, 1'b1, 16'h54cc},
  '{6, 2'd3, ac_pkg::op_add_lp,  4'h6, 16'h0001, 1'b1, 16'h54cd},  // Burst to far tile
  '{6, 2'd3, ac_pkg::op_add_lp,  4'h7, 16'h0001, 1'b1, 16'h54ce},
  '{6, 2'd3, ac_pkg::op_add_lp,  4'h8, 16'h0001, 1'b1, 16'h54cf},
  '{6, 2'd3, ac_pkg::op_add_lp,  4'h9, 16'h0001, 1'b1, 16'h54d0},
  '{6, 2'd3, ac_pkg::op_read_lp, 4'ha, 16'h0000, 1'b1, 16'h54d0}
};

/* verif/ac_complex_tb.sv */
`default_nettype none

module ac_complex_tb;

  typedef struct packed
  {
    int              test_id;
    ac_pkg::cord_t   dest;
    ac_pkg::opcode_t op;
    ac_pkg::tag_t    tag;
    ac_pkg::data_t   operand;
    logic            has_resp;
    ac_pkg::data_t   exp_data;
  } vec_t;

  `include "ac_tb_vectors.svh"

  localparam int num_tests_lp = 6;
  localparam int limit_lp     = num_vec_lp * 40 + 200;

  logic               core_clk_i   = 1'b0;
  logic               arst_n_i;
  ac_pkg::cmd_flit_t  cmd_flit_i;
  logic               cmd_valid_i;
  logic               cmd_ready_o;
  ac_pkg::resp_flit_t resp_flit_o;
  logic               resp_valid_o;
  logic               resp_ready_i = 1'b1;

  int                 cycles   = 0;
  int                 drv_errs = 0;
  int                 mon_errs = 0;
  logic               bp_on    = 1'b0;
  int unsigned        stretch  = 0;
  logic               sent    [num_vec_lp] = '{default: 1'b0};
  int                 got_cnt [num_vec_lp] = '{default: 0};
  ac_pkg::data_t      model_acc [ac_pkg::num_tiles_lp];
  string              test_name [1:num_tests_lp] = '{"reset state", "opcode rules", "routing",
                                                     "pass-through", "back-pressure", "throughput"};

  ac_complex ac_complex_i
    (.core_clk_i   (core_clk_i),
     .arst_n_i     (arst_n_i),
     .cmd_flit_i   (cmd_flit_i),
     .cmd_valid_i  (cmd_valid_i),
     .cmd_ready_o  (cmd_ready_o),
     .resp_flit_o  (resp_flit_o),
     .resp_valid_o (resp_valid_o),
     .resp_ready_i (resp_ready_i)
    );

  always #2 core_clk_i = ~core_clk_i;

  function automatic ac_pkg::data_t apply_op(ac_pkg::opcode_t op, ac_pkg::data_t acc,
                                             ac_pkg::data_t operand);
    case (op)
      ac_pkg::op_load_lp: return operand;
      ac_pkg::op_add_lp:  return acc + operand;  // Mod 2^16 by width
      ac_pkg::op_xor_lp:  return acc ^ operand;
      default:            return acc;
    endcase
  endfunction

  function automatic logic is_pending(int k);
    return sent[k] && vec_tbl[k].has_resp && got_cnt[k] == 0;
  endfunction

  function automatic int count_pending();
    int n;
    n = 0;
    for (int k = 0; k < num_vec_lp; k++)
      if (is_pending(k))
        n++;
    return n;
  endfunction

  task automatic check_idle();
    if (resp_valid_o !== 1'b0)
    begin
      $display("** Error at %0t: resp_valid_o = %b, expected 0", $time, resp_valid_o);
      drv_errs++;
    end
  endtask

  task automatic send_cmd(int i);
    @(negedge core_clk_i);
    cmd_flit_i  = {vec_tbl[i].dest, vec_tbl[i].op, vec_tbl[i].tag, vec_tbl[i].operand};
    cmd_valid_i = 1'b1;
    sent[i]     = 1'b1;
    do
      @(posedge core_clk_i);
    while (!cmd_ready_o);  // Held until accepted
  endtask

  // Ready held high or low for 1 to 6 cycles at a time
  always @(negedge core_clk_i)
  begin
    if (!bp_on)
      resp_ready_i = 1'b1;
    else if (stretch == 0)
    begin
      resp_ready_i = ($urandom_range(1, 0) == 1);
      stretch      = $urandom_range(5, 0);
    end
    else
      stretch = stretch - 1;
  end

  always @(posedge core_clk_i)
  begin
    int            hit;
    ac_pkg::cord_t src;
    ac_pkg::tag_t  tag;
    ac_pkg::data_t data;
    if (resp_valid_o && resp_ready_i)
    begin
      {src, tag, data} = resp_flit_o;
      hit = -1;
      for (int k = 0; k < num_vec_lp; k++)
        if (is_pending(k) && vec_tbl[k].tag == tag)
          hit = k;
      if (hit < 0)
      begin
        $display("Unexpected response at %0t: tile %0d tag %h matches no outstanding command",
                 $time, src, tag);
        mon_errs++;
      end
      else
      begin
        for (int k = 0; k < hit; k++)
          if (is_pending(k) && vec_tbl[k].dest == vec_tbl[hit].dest)
          begin
            $display("Out of order at %0t: tag %h from tile %0d arrived before tag %h",
                     $time, tag, src, vec_tbl[k].tag);
            mon_errs++;
          end
        got_cnt[hit]++;
        if (src != vec_tbl[hit].dest)
        begin
          $display("** Error at %0t: resp_flit_o.src = %0d, expected %0d (tag %h)",
                   $time, src, vec_tbl[hit].dest, tag);
          mon_errs++;
        end
        if (data != vec_tbl[hit].exp_data)
        begin
          $display("** Error at %0t: resp_flit_o.result = %h, expected %h (tag %h)",
                   $time, data, vec_tbl[hit].exp_data, tag);
          mon_errs++;
        end
      end
    end
  end

  always @(posedge core_clk_i)
  begin
    cycles++;
    if (cycles >= limit_lp)
    begin
      $display("Timeout after %0d cycles, these commands never completed", cycles);
      for (int k = 0; k < num_vec_lp; k++)
        if (is_pending(k))
          $display("  row %0d tile %0d tag %h", k, vec_tbl[k].dest, vec_tbl[k].tag);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial
  begin
    int            errs_before;
    int            errs;
    int            n_cmds;
    int            failed_tests;
    ac_pkg::data_t model_val;
    void'($urandom(32'hacf7c98d));
    errs_before  = 0;
    failed_tests = 0;
    arst_n_i     = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_flit_i   = '0;
    for (int t = 0; t < ac_pkg::num_tiles_lp; t++)
      model_acc[t] = '0;
    repeat (3)
    begin
      @(negedge core_clk_i);
      check_idle();
    end
    arst_n_i = 1'b1;
    @(negedge core_clk_i);
    check_idle();

    for (int t = 1; t <= num_tests_lp; t++)
    begin
      n_cmds = 0;
      bp_on  = (t == 5);
      for (int i = 0; i < num_vec_lp; i++)
        if (vec_tbl[i].test_id == t)
        begin
          model_val = apply_op(vec_tbl[i].op, model_acc[vec_tbl[i].dest], vec_tbl[i].operand);
          model_acc[vec_tbl[i].dest] = model_val;
          if (model_val != vec_tbl[i].exp_data)
          begin
            $display("Table row %0d expects %h but the opcode rules give %h",
                     i, vec_tbl[i].exp_data, model_val);
            drv_errs++;
          end
          send_cmd(i);
          n_cmds++;
        end
      @(negedge core_clk_i);
      cmd_valid_i = 1'b0;
      while (count_pending() != 0)
        @(posedge core_clk_i);
      bp_on = 1'b0;
      errs  = drv_errs + mon_errs - errs_before;
      errs_before = drv_errs + mon_errs;
      if (errs != 0)
        failed_tests++;
      $display("Test %0d %s: %0d commands, %0d errors, %s",
               t, test_name[t], n_cmds, errs, (errs == 0) ? "ok" : "failed");
    end

    $display("Summary %0d tests, %0d failed, %0d errors in %0d cycles",
             num_tests_lp, failed_tests, drv_errs + mon_errs, cycles);
    if (failed_tests == 0 && drv_errs + mon_errs == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* ac_complex.f */
+incdir+verif
src/ac_pkg.sv
src/ac_link_fifo.sv
src/ac_tile_router.sv
src/ac_accum_engine.sv
src/ac_tile_node.sv
src/ac_complex.sv
verif/ac_complex_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f ac_complex.f --top-module ac_complex_tb -o ac_complex_sim

out=$(./obj_dir/ac_complex_sim || true)
echo "$out"

if echo "$out" | grep -qx 'ALL TESTS PASSED'; then
  exit 0
fi
exit 1
